// ==== rtl/vmul_params.svh ====
// Widths, queue depths and multiplier latencies of the vector multiply unit

`ifndef VMUL_PARAMS_SVH
`define VMUL_PARAMS_SVH

// Operand word and instruction bookkeeping
`define VMUL_ELEN       64
`define VMUL_INSN_DEPTH 4
`define VMUL_RESQ_DEPTH 2
`define VMUL_NR_IDS     8
`define VMUL_VL_W       7

// Pipeline registers per element width
`define VMUL_LAT_EW64   3
`define VMUL_LAT_EW32   2
`define VMUL_LAT_EW16   1
`define VMUL_LAT_EW8    1

`endif

// ==== rtl/vmul_insn_pkg.sv ====
// Instruction-side types of the vector multiply unit
// Opcodes, element widths, the queued instruction and a width helper

`default_nettype none
`include "vmul_params.svh"

package vmul_insn_pkg;

  typedef enum logic [1:0] {VMUL, VMULH, VMULHU, VMACC} vmul_op_e;
  typedef enum logic [1:0] {EW8 = 2'd0, EW16 = 2'd1, EW32 = 2'd2, EW64 = 2'd3} vsew_e;

  typedef logic [$clog2(`VMUL_NR_IDS)-1:0] vid_t;
  typedef logic [4:0]                      vreg_t;
  typedef logic [`VMUL_VL_W-1:0]           vlen_t;

  typedef struct packed {
    vmul_op_e              op;
    vsew_e                 vsew;
    vlen_t                 vl;
    vreg_t                 vd;
    vid_t                  id;
    logic                  use_scalar;
    logic [`VMUL_ELEN-1:0] scalar;
  } vmul_insn_t;

  // Elements of the given width in one operand word
  function automatic logic [3:0] elems_per_word(vsew_e vsew);
    return 4'd8 >> vsew;
  endfunction

endpackage

`default_nettype wire

// ==== rtl/vmul_data_pkg.sv ====
// Data-side types of the vector multiply unit
// Operand words, multiplier requests and register-file writes

`default_nettype none
`include "vmul_params.svh"

package vmul_data_pkg;
  import vmul_insn_pkg::*;

  typedef logic [`VMUL_ELEN-1:0]   elen_t;
  typedef logic [`VMUL_ELEN/8-1:0] strb_t;
  // Register number on top, word index within the register below
  typedef logic [$bits(vreg_t)+`VMUL_VL_W-2:0] vaddr_t;

  typedef struct packed {
    elen_t    a;
    elen_t    b;
    elen_t    c;
    vmul_op_e op;
  } mul_req_t;

  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } vrf_wr_t;

endpackage

`default_nettype wire

// ==== rtl/vmul_insn_queue.sv ====
// Instruction queue of the vector multiply unit
// Issue sequencing, scalar replication and lane routing of operand words

`timescale 1ns/1ps
`default_nettype none
`include "vmul_params.svh"

module vmul_insn_queue import vmul_insn_pkg::*; import vmul_data_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire vmul_insn_t insn_i,
  input  wire logic       insn_valid_i,
  output logic            insn_ready_o,
  input  wire mul_req_t   opnd_i,
  input  wire logic       opnd_valid_i,
  output logic            opnd_ready_o,
  output mul_req_t        lane_req_o,
  output logic [3:0]      lane_valid_o,
  input  wire logic [3:0] lane_ready_i,
  output vmul_insn_t      proc_insn_o,
  output logic            proc_valid_o,
  input  wire logic       proc_done_i,
  output vmul_insn_t      commit_insn_o,
  output logic            commit_valid_o,
  input  wire logic       commit_done_i
);

  localparam int unsigned Depth = `VMUL_INSN_DEPTH;
  localparam int unsigned PntW  = $clog2(Depth);

  typedef logic [PntW-1:0] pnt_t;
  typedef logic [PntW:0]   cnt_t;

  vmul_insn_t insn_q [Depth];
  pnt_t       accept_pnt_q, issue_pnt_q, proc_pnt_q, commit_pnt_q;
  cnt_t       issue_cnt_q, proc_cnt_q, commit_cnt_q;
  vlen_t      issued_q;

  vmul_insn_t issue_insn;
  logic       accept, issue_valid, issue_fire, issue_last;
  vlen_t      issue_rem;
  logic [3:0] per_word;
  elen_t      scalar_rep;

  // Commit count bounds the queue, an entry frees only once written back
  assign insn_ready_o = (commit_cnt_q < cnt_t'(Depth));
  assign accept       = insn_valid_i && insn_ready_o;

  assign issue_insn  = insn_q[issue_pnt_q];
  assign issue_valid = (issue_cnt_q != '0);
  assign per_word    = elems_per_word(issue_insn.vsew);
  assign issue_rem   = issue_insn.vl - issued_q;
  assign issue_last  = (issue_rem <= vlen_t'(per_word));

  assign opnd_ready_o = issue_valid && lane_ready_i[issue_insn.vsew];
  assign issue_fire   = opnd_ready_o && opnd_valid_i;

  always_comb begin
    case (issue_insn.vsew)
      EW8:     scalar_rep = {8{issue_insn.scalar[7:0]}};
      EW16:    scalar_rep = {4{issue_insn.scalar[15:0]}};
      EW32:    scalar_rep = {2{issue_insn.scalar[31:0]}};
      default: scalar_rep = issue_insn.scalar;
    endcase
  end

  // Same payload to every lane, only the selected lane sees valid
  always_comb begin
    lane_req_o    = opnd_i;
    lane_req_o.op = issue_insn.op;
    if (issue_insn.use_scalar) begin
      lane_req_o.a = scalar_rep;
    end
    lane_valid_o = '0;
    if (issue_valid) begin
      lane_valid_o[issue_insn.vsew] = opnd_valid_i;
    end
  end

  assign proc_insn_o    = insn_q[proc_pnt_q];
  assign proc_valid_o   = (proc_cnt_q != '0);
  assign commit_insn_o  = insn_q[commit_pnt_q];
  assign commit_valid_o = (commit_cnt_q != '0);

  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[accept_pnt_q] <= insn_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      proc_pnt_q   <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      proc_cnt_q   <= '0;
      commit_cnt_q <= '0;
      issued_q     <= '0;
    end else begin
      if (accept) accept_pnt_q <= accept_pnt_q + 1'b1;
      if (issue_fire && issue_last) issue_pnt_q <= issue_pnt_q + 1'b1;
      if (proc_done_i) proc_pnt_q <= proc_pnt_q + 1'b1;
      if (commit_done_i) commit_pnt_q <= commit_pnt_q + 1'b1;
      issue_cnt_q  <= issue_cnt_q + cnt_t'(accept) - cnt_t'(issue_fire && issue_last);
      proc_cnt_q   <= proc_cnt_q + cnt_t'(accept) - cnt_t'(proc_done_i);
      commit_cnt_q <= commit_cnt_q + cnt_t'(accept) - cnt_t'(commit_done_i);
      // Elements already sent for the issuing instruction
      if (issue_fire) begin
        issued_q <= issue_last ? '0 : issued_q + vlen_t'(per_word);
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/simd_mul.sv ====
// SIMD integer multiplier for one element width
// Low, signed high, unsigned high and accumulate, with a stallable pipeline

`timescale 1ns/1ps
`default_nettype none
`include "vmul_params.svh"

module simd_mul import vmul_insn_pkg::*; import vmul_data_pkg::*; #(
  parameter int unsigned ElementWidth = 64,
  parameter int unsigned NumPipeRegs  = 1
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire mul_req_t req_i,
  input  wire logic     valid_i,
  output logic          ready_o,
  output elen_t         result_o,
  output logic          valid_o,
  input  wire logic     ready_i
);

  localparam int unsigned Ew       = ElementWidth;
  localparam int unsigned NumElems = `VMUL_ELEN / ElementWidth;

  elen_t                   result_d;
  elen_t [NumPipeRegs-1:0] stage_q;
  logic  [NumPipeRegs-1:0] stage_valid_q;
  logic                    en;

  for (genvar e = 0; e < NumElems; e++) begin : gen_elem
    logic [Ew-1:0]   a, b, c, res;
    logic [2*Ew-1:0] prod_u, prod_s;

    assign a = req_i.a[e*Ew +: Ew];
    assign b = req_i.b[e*Ew +: Ew];
    assign c = req_i.c[e*Ew +: Ew];

    assign prod_u = {{Ew{1'b0}}, a} * {{Ew{1'b0}}, b};
    // Sign-extended inputs, the low 2*Ew bits hold the signed product
    assign prod_s = {{Ew{a[Ew-1]}}, a} * {{Ew{b[Ew-1]}}, b};

    always_comb begin
      case (req_i.op)
        VMULH:   res = prod_s[2*Ew-1:Ew];
        VMULHU:  res = prod_u[2*Ew-1:Ew];
        VMACC:   res = c + prod_u[Ew-1:0];
        default: res = prod_u[Ew-1:0];
      endcase
    end

    assign result_d[e*Ew +: Ew] = res;
  end

  // A held output freezes every stage
  assign en       = ready_i || !valid_o;
  assign ready_o  = en;
  assign valid_o  = stage_valid_q[NumPipeRegs-1];
  assign result_o = stage_q[NumPipeRegs-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_valid_q <= '0;
    end else if (en) begin
      stage_valid_q[0] <= valid_i;
      for (int s = 1; s < NumPipeRegs; s++) begin
        stage_valid_q[s] <= stage_valid_q[s-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (en) begin
      stage_q[0] <= result_d;
      for (int s = 1; s < NumPipeRegs; s++) begin
        stage_q[s] <= stage_q[s-1];
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/vmul_result_queue.sv ====
// Result queue of the vector multiply unit
// In-order draining of the multipliers, register-file writes and done pulses

`timescale 1ns/1ps
`default_nettype none
`include "vmul_params.svh"

module vmul_result_queue import vmul_insn_pkg::*; import vmul_data_pkg::*; (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire elen_t [3:0]         lane_result_i,
  input  wire logic  [3:0]         lane_valid_i,
  output logic       [3:0]         lane_ready_o,
  input  wire vmul_insn_t          proc_insn_i,
  input  wire logic                proc_valid_i,
  output logic                     proc_done_o,
  input  wire vmul_insn_t          commit_insn_i,
  input  wire logic                commit_valid_i,
  output logic                     commit_done_o,
  output vrf_wr_t                  vrf_wr_o,
  output logic                     vrf_req_o,
  input  wire logic                vrf_gnt_i,
  output logic [`VMUL_NR_IDS-1:0]  insn_done_o
);

  localparam int unsigned Depth = `VMUL_RESQ_DEPTH;
  localparam int unsigned PntW  = $clog2(Depth);

  vrf_wr_t         queue_q [Depth];
  logic [PntW-1:0] wr_pnt_q, rd_pnt_q;
  logic [PntW:0]   cnt_q;
  vlen_t           proc_elem_q, commit_elem_q;

  logic       full, take, pop;
  vlen_t      proc_rem, commit_rem;
  logic [3:0] proc_per, commit_per;
  vrf_wr_t    entry;

  assign full     = (cnt_q == Depth);
  assign proc_per = elems_per_word(proc_insn_i.vsew);
  assign proc_rem = proc_insn_i.vl - proc_elem_q;

  // Only the lane of the oldest unprocessed instruction is drained
  always_comb begin
    lane_ready_o = '0;
    if (proc_valid_i && !full) begin
      lane_ready_o[proc_insn_i.vsew] = 1'b1;
    end
  end

  assign take        = proc_valid_i && !full && lane_valid_i[proc_insn_i.vsew];
  assign proc_done_o = take && (proc_rem <= vlen_t'(proc_per));

  always_comb begin
    logic [3:0] nelem;
    logic [3:0] nbytes;
    vlen_t      word_idx;
    // Last word of an instruction may be partly filled
    nelem    = (proc_rem < vlen_t'(proc_per)) ? proc_rem[3:0] : proc_per;
    nbytes   = nelem << proc_insn_i.vsew;
    word_idx = proc_elem_q >> (3 - int'(proc_insn_i.vsew));
    entry.id    = proc_insn_i.id;
    entry.addr  = {proc_insn_i.vd, word_idx[`VMUL_VL_W-2:0]};
    entry.wdata = lane_result_i[proc_insn_i.vsew];
    entry.be    = strb_t'((9'd1 << nbytes) - 9'd1);
  end

  assign vrf_req_o  = (cnt_q != '0);
  assign vrf_wr_o   = queue_q[rd_pnt_q];
  assign pop        = vrf_req_o && vrf_gnt_i;
  assign commit_per = elems_per_word(commit_insn_i.vsew);
  assign commit_rem = commit_insn_i.vl - commit_elem_q;

  assign commit_done_o = pop && commit_valid_i && (commit_rem <= vlen_t'(commit_per));

  always_comb begin
    insn_done_o = '0;
    if (commit_done_o) begin
      insn_done_o[commit_insn_i.id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      queue_q[wr_pnt_q] <= entry;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q      <= '0;
      rd_pnt_q      <= '0;
      cnt_q         <= '0;
      proc_elem_q   <= '0;
      commit_elem_q <= '0;
    end else begin
      if (take) wr_pnt_q <= wr_pnt_q + 1'b1;
      if (pop) rd_pnt_q <= rd_pnt_q + 1'b1;
      cnt_q <= cnt_q + (PntW+1)'(take) - (PntW+1)'(pop);
      if (take) begin
        proc_elem_q <= proc_done_o ? '0 : proc_elem_q + vlen_t'(proc_per);
      end
      if (pop) begin
        commit_elem_q <= commit_done_o ? '0 : commit_elem_q + vlen_t'(commit_per);
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/vmul_unit.sv ====
// Top level of the vector multiply unit
// Instruction queue, one SIMD multiplier per element width, result queue

`timescale 1ns/1ps
`default_nettype none
`include "vmul_params.svh"

module vmul_unit import vmul_insn_pkg::*; import vmul_data_pkg::*; (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire vmul_insn_t         insn_i,
  input  wire logic               insn_valid_i,
  output logic                    insn_ready_o,
  input  wire mul_req_t           opnd_i,
  input  wire logic               opnd_valid_i,
  output logic                    opnd_ready_o,
  output vrf_wr_t                 vrf_wr_o,
  output logic                    vrf_req_o,
  input  wire logic               vrf_gnt_i,
  output logic [`VMUL_NR_IDS-1:0] insn_done_o
);

  localparam int unsigned NumLanes = 4;

  mul_req_t              lane_req;
  logic [NumLanes-1:0]   lane_valid, lane_ready, res_valid, res_ready;
  elen_t [NumLanes-1:0]  lane_result;
  vmul_insn_t            proc_insn, commit_insn;
  logic                  proc_valid, proc_done, commit_valid, commit_done;

  vmul_insn_queue u_insn_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .insn_i        (insn_i),
    .insn_valid_i  (insn_valid_i),
    .insn_ready_o  (insn_ready_o),
    .opnd_i        (opnd_i),
    .opnd_valid_i  (opnd_valid_i),
    .opnd_ready_o  (opnd_ready_o),
    .lane_req_o    (lane_req),
    .lane_valid_o  (lane_valid),
    .lane_ready_i  (lane_ready),
    .proc_insn_o   (proc_insn),
    .proc_valid_o  (proc_valid),
    .proc_done_i   (proc_done),
    .commit_insn_o (commit_insn),
    .commit_valid_o(commit_valid),
    .commit_done_i (commit_done)
  );

  // Lane index equals the element width encoding
  for (genvar i = 0; i < NumLanes; i++) begin : gen_mul
    localparam int unsigned Lat = (i == 0) ? `VMUL_LAT_EW8  :
                                  (i == 1) ? `VMUL_LAT_EW16 :
                                  (i == 2) ? `VMUL_LAT_EW32 : `VMUL_LAT_EW64;

    simd_mul #(
      .ElementWidth(8 << i),
      .NumPipeRegs (Lat)
    ) u_mul (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (lane_req),
      .valid_i (lane_valid[i]),
      .ready_o (lane_ready[i]),
      .result_o(lane_result[i]),
      .valid_o (res_valid[i]),
      .ready_i (res_ready[i])
    );
  end

  vmul_result_queue u_result_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lane_result_i (lane_result),
    .lane_valid_i  (res_valid),
    .lane_ready_o  (res_ready),
    .proc_insn_i   (proc_insn),
    .proc_valid_i  (proc_valid),
    .proc_done_o   (proc_done),
    .commit_insn_i (commit_insn),
    .commit_valid_i(commit_valid),
    .commit_done_o (commit_done),
    .vrf_wr_o      (vrf_wr_o),
    .vrf_req_o     (vrf_req_o),
    .vrf_gnt_i     (vrf_gnt_i),
    .insn_done_o   (insn_done_o)
  );

endmodule

`default_nettype wire

// ==== tests/tb_clk_gen.sv ====
// Clock and reset generator of the testbench

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned Period      = 8,
  parameter int unsigned ResetCycles = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  // Reset released just after the last reset edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tests/vmul_unit_scoreboard.sv ====
// Scoreboard of the vector multiply unit
// Expected register-file writes, done pulse checks and per-test lines

`timescale 1ns/1ps
`default_nettype none
`include "vmul_params.svh"

module vmul_unit_scoreboard import vmul_data_pkg::*; (
  input wire logic                    clk_i,
  input wire logic                    rst_ni,
  input wire vrf_wr_t                 vrf_wr_i,
  input wire logic                    vrf_req_i,
  input wire logic                    vrf_gnt_i,
  input wire logic [`VMUL_NR_IDS-1:0] insn_done_i
);

  vrf_wr_t     exp_q [$];
  logic        last_q [$];
  string       test_name = "none";
  int unsigned test_errs = 0;
  int unsigned total_errs = 0;
  int unsigned tests_run = 0;
  int unsigned tests_failed = 0;
  int unsigned test_words = 0;

  vrf_wr_t                 exp_wr;
  logic                    exp_last;
  logic [`VMUL_NR_IDS-1:0] exp_done;

  task automatic expect_write(vrf_wr_t wr, logic last);
    exp_q.push_back(wr);
    last_q.push_back(last);
  endtask

  function automatic int pending();
    return exp_q.size();
  endfunction

  task automatic begin_test(string name);
    test_name  = name;
    test_errs  = 0;
    test_words = 0;
  endtask

  task automatic end_test();
    tests_run++;
    total_errs += test_errs;
    if (test_errs != 0) begin
      tests_failed++;
    end
    $display("test %-13s %s, %0d writes checked", test_name,
             (test_errs == 0) ? "ok" : "FAILED", test_words);
  endtask

  task automatic check_field(string field, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, field,
               expected, actual);
      test_errs++;
    end
  endtask

  task automatic report_error(string msg);
    $display("ERROR in %s: %s", test_name, msg);
    test_errs++;
  endtask

  // Every granted write must match the oldest expectation
  always @(posedge clk_i) begin
    if (rst_ni && vrf_req_i && vrf_gnt_i) begin
      if (exp_q.size() == 0) begin
        report_error("register-file write granted while no write was expected");
      end else begin
        exp_wr   = exp_q.pop_front();
        exp_last = last_q.pop_front();
        exp_done = '0;
        if (exp_last) begin
          exp_done[exp_wr.id] = 1'b1;
        end
        check_field("id", exp_wr.id, vrf_wr_i.id);
        check_field("addr", exp_wr.addr, vrf_wr_i.addr);
        check_field("wdata", exp_wr.wdata, vrf_wr_i.wdata);
        check_field("be", exp_wr.be, vrf_wr_i.be);
        check_field("done", exp_done, insn_done_i);
        test_words++;
      end
    end else if (rst_ni && insn_done_i != '0) begin
      report_error("done pulse raised without a granted write");
    end
  end

endmodule

`default_nettype wire

// ==== tests/vmul_unit_chk.sv ====
// Assertions bound to the vector multiply unit
// Write payload stability, one-hot done pulses and reset state

`timescale 1ns/1ps
`default_nettype none
`include "vmul_params.svh"

module vmul_unit_chk import vmul_data_pkg::*; (
  input wire logic                    clk_i,
  input wire logic                    rst_ni,
  input wire vrf_wr_t                 vrf_wr_i,
  input wire logic                    vrf_req_i,
  input wire logic                    vrf_gnt_i,
  input wire logic                    insn_ready_i,
  input wire logic                    opnd_ready_i,
  input wire logic [`VMUL_NR_IDS-1:0] insn_done_i
);

  int unsigned fail_cnt = 0;
  logic        in_reset_q;

  // High once a clock edge has seen reset asserted
  always_ff @(posedge clk_i) begin
    in_reset_q <= !rst_ni;
  end

  wr_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    vrf_req_i && !vrf_gnt_i |=> vrf_req_i && $stable(vrf_wr_i))
  else begin
    fail_cnt++;
    $error("write request dropped or payload changed without a grant");
  end

  // A done bit belongs to the granted write and names that write's id
  done_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    insn_done_i != '0 |->
      vrf_req_i && vrf_gnt_i && $onehot(insn_done_i) && insn_done_i[vrf_wr_i.id])
  else begin
    fail_cnt++;
    $error("done pulse not one-hot or not on a granted write of that id");
  end

  reset_state_a: assert property (@(posedge clk_i)
    !rst_ni && in_reset_q |-> !vrf_req_i && insn_done_i == '0 && !opnd_ready_i && insn_ready_i)
  else begin
    fail_cnt++;
    $error("outputs not in their reset state during reset");
  end

endmodule

bind vmul_unit vmul_unit_chk u_chk (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .vrf_wr_i    (vrf_wr_o),
  .vrf_req_i   (vrf_req_o),
  .vrf_gnt_i   (vrf_gnt_i),
  .insn_ready_i(insn_ready_o),
  .opnd_ready_i(opnd_ready_o),
  .insn_done_i (insn_done_o)
);

`default_nettype wire

// ==== tests/tb_vmul_unit.sv ====
// Testbench top of the vector multiply unit
// Stimulus, xorshift operands, reference model and timeout

`timescale 1ns/1ps
`default_nettype none
`include "vmul_params.svh"

module tb_vmul_unit import vmul_insn_pkg::*; import vmul_data_pkg::*; ();

  localparam logic [31:0] Seed     = 32'h6eb23cfe;
  localparam int          NumTests = 5;

  logic                    clk, rst_n;
  vmul_insn_t              insn;
  logic                    insn_valid, insn_ready;
  mul_req_t                opnd;
  logic                    opnd_valid, opnd_ready;
  vrf_wr_t                 vrf_wr;
  logic                    vrf_req, vrf_gnt;
  logic [`VMUL_NR_IDS-1:0] insn_done;

  logic [31:0] rng, gnt_rng;
  logic        gnt_random, gnt_random_s;
  vid_t        next_id;
  string       names [NumTests] = '{"vmul_vv", "vmulh_vmulhu", "vmacc_vx", "partial_vl",
                                    "backpressure"};

  tb_clk_gen #(.Period(8), .ResetCycles(3)) u_clk_gen (.clk_o(clk), .rst_no(rst_n));

  vmul_unit u_dut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .insn_i      (insn),
    .insn_valid_i(insn_valid),
    .insn_ready_o(insn_ready),
    .opnd_i      (opnd),
    .opnd_valid_i(opnd_valid),
    .opnd_ready_o(opnd_ready),
    .vrf_wr_o    (vrf_wr),
    .vrf_req_o   (vrf_req),
    .vrf_gnt_i   (vrf_gnt),
    .insn_done_o (insn_done)
  );

  vmul_unit_scoreboard u_sb (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .vrf_wr_i   (vrf_wr),
    .vrf_req_i  (vrf_req),
    .vrf_gnt_i  (vrf_gnt),
    .insn_done_i(insn_done)
  );

  function automatic logic [31:0] xorshift(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic elen_t splat(elen_t scalar, vsew_e sew);
    int unsigned w;
    elen_t       mask, res;
    w    = 8 << sew;
    mask = (w == 64) ? '1 : (64'd1 << w) - 64'd1;
    res  = '0;
    for (int e = 0; e < 64 / w; e++) begin
      res = res | ((scalar & mask) << (e * w));
    end
    return res;
  endfunction

  // Expected word, element by element in 128-bit arithmetic
  function automatic elen_t ref_word(vmul_op_e op, vsew_e sew, elen_t a, elen_t b, elen_t c);
    int unsigned  w;
    elen_t        mask, ea, eb, ec, r, res;
    logic [127:0] ua, ub, sa, sb, pu, ps;
    w    = 8 << sew;
    mask = (w == 64) ? '1 : (64'd1 << w) - 64'd1;
    res  = '0;
    for (int e = 0; e < 64 / w; e++) begin
      ea = (a >> (e * w)) & mask;
      eb = (b >> (e * w)) & mask;
      ec = (c >> (e * w)) & mask;
      ua = {64'd0, ea};
      ub = {64'd0, eb};
      sa = ea[w-1] ? (ua | ~{64'd0, mask}) : ua;
      sb = eb[w-1] ? (ub | ~{64'd0, mask}) : ub;
      pu = ua * ub;
      ps = sa * sb;
      case (op)
        VMULH:   r = elen_t'(ps >> w);
        VMULHU:  r = elen_t'(pu >> w);
        VMACC:   r = ec + pu[63:0];
        default: r = pu[63:0];
      endcase
      res = res | ((r & mask) << (e * w));
    end
    return res;
  endfunction

  function automatic int test_len(int t);
    return (t == 2) ? 2 : (t == 3) ? 3 : 4;
  endfunction

  function automatic vmul_insn_t test_insn(int t, int k);
    vmul_insn_t i;
    i    = '0;
    i.vd = vreg_t'(4 * t + k);
    case (t)
      0: begin
        i.op   = VMUL;
        i.vsew = vsew_e'(k);
        i.vl   = vlen_t'(16 >> k);
      end
      1: begin
        i.op   = k[0] ? VMULHU : VMULH;
        i.vsew = (k < 2) ? EW8 : EW64;
        i.vl   = (k < 2) ? vlen_t'(16) : vlen_t'(3);
      end
      2: begin
        i.op         = VMACC;
        i.use_scalar = 1'b1;
        i.vsew       = (k == 0) ? EW16 : EW32;
        i.vl         = (k == 0) ? vlen_t'(12) : vlen_t'(6);
        i.scalar     = (k == 0) ? 64'h5a5a_0000_0000_c35a : 64'hffff_ffff_9e37_79b9;
      end
      3: begin
        // Last word only partly filled at every width
        i.op   = VMUL;
        i.vsew = vsew_e'(k);
        i.vl   = vlen_t'(13 >> k);
      end
      default: begin
        i.op   = vmul_op_e'(k);
        i.vsew = vsew_e'(3 - k);
        i.vl   = vlen_t'(5 + 4 * k);
      end
    endcase
    return i;
  endfunction

  function automatic int num_words(vmul_insn_t i);
    return (int'(i.vl) * (8 << i.vsew) + 63) / 64;
  endfunction

  function automatic int timeout_cycles();
    int words;
    words = 0;
    for (int t = 0; t < NumTests; t++) begin
      for (int k = 0; k < test_len(t); k++) begin
        words += num_words(test_insn(t, k));
      end
    end
    return 40 * words + 200;
  endfunction

  task automatic draw64(output elen_t v);
    rng = xorshift(rng);
    v[63:32] = rng;
    rng = xorshift(rng);
    v[31:0] = rng;
  endtask

  task automatic send_insn(vmul_insn_t i);
    insn       = i;
    insn_valid = 1'b1;
    do @(posedge clk); while (!insn_ready);
    #1;
    insn_valid = 1'b0;
  endtask

  task automatic send_word(elen_t a, elen_t b, elen_t c);
    opnd       = '{a: a, b: b, c: c, op: VMUL};
    opnd_valid = 1'b1;
    do @(posedge clk); while (!opnd_ready);
    #1;
    opnd_valid = 1'b0;
  endtask

  // Expected writes are queued before each word is offered
  task automatic send_operands(vmul_insn_t i);
    int      per, rem, nelem, nbytes;
    elen_t   a, b, c, a_eff;
    vrf_wr_t exp;
    per = 8 >> i.vsew;
    rem = int'(i.vl);
    for (int w = 0; rem > 0; w++) begin
      draw64(a);
      draw64(b);
      draw64(c);
      if (w == 0 && i.op inside {VMULH, VMULHU}) begin
        a = a | 64'h8080_8080_8080_8080;
      end
      a_eff     = i.use_scalar ? splat(i.scalar, i.vsew) : a;
      nelem     = (rem < per) ? rem : per;
      nbytes    = nelem << i.vsew;
      exp.id    = i.id;
      exp.addr  = vaddr_t'(i.vd * 64 + w);
      exp.wdata = ref_word(i.op, i.vsew, a_eff, b, c);
      exp.be    = strb_t'((16'd1 << nbytes) - 16'd1);
      u_sb.expect_write(exp, rem <= per);
      send_word(a, b, c);
      rem = rem - per;
    end
  endtask

  task automatic run_test(int t);
    vmul_insn_t q [4];
    u_sb.begin_test(names[t]);
    gnt_random = (t == NumTests - 1);
    for (int k = 0; k < test_len(t); k++) begin
      q[k]    = test_insn(t, k);
      q[k].id = next_id;
      next_id++;
      send_insn(q[k]);
    end
    if (t == NumTests - 1) begin
      // A fifth instruction must be refused
      insn       = test_insn(t, 0);
      insn.id    = next_id;
      insn_valid = 1'b1;
      @(posedge clk);
      u_sb.check_field("insn_ready with four outstanding", 64'd0, insn_ready);
      #1;
      insn_valid = 1'b0;
    end
    for (int k = 0; k < test_len(t); k++) begin
      send_operands(q[k]);
    end
    while (u_sb.pending() != 0) @(posedge clk);
    @(posedge clk);
    #1;
    gnt_random = 1'b0;
    u_sb.end_test();
  endtask

  // Grant driver, random only while the back-pressure test runs
  initial begin
    vrf_gnt = 1'b0;
    gnt_rng = Seed;
    forever begin
      @(posedge clk);
      gnt_random_s = gnt_random;
      #1;
      if (gnt_random_s) begin
        gnt_rng = xorshift(gnt_rng);
        vrf_gnt = gnt_rng[3];
      end else begin
        vrf_gnt = 1'b1;
      end
    end
  end

  initial begin
    repeat (timeout_cycles()) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", timeout_cycles());
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    insn       = '0;
    insn_valid = 1'b0;
    opnd       = '0;
    opnd_valid = 1'b0;
    rng        = Seed;
    next_id    = '0;
    gnt_random = 1'b0;
    @(posedge rst_n);
    @(posedge clk);
    #1;
    u_sb.begin_test("reset");
    u_sb.check_field("vrf_req", 64'd0, vrf_req);
    u_sb.check_field("insn_done", 64'd0, insn_done);
    u_sb.check_field("insn_ready", 64'd1, insn_ready);
    u_sb.check_field("opnd_ready", 64'd0, opnd_ready);
    u_sb.end_test();
    for (int t = 0; t < NumTests; t++) begin
      run_test(t);
    end
    $display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
             u_sb.tests_run, u_sb.tests_failed, u_sb.total_errs, u_dut.u_chk.fail_cnt);
    if (u_sb.total_errs == 0 && u_dut.u_chk.fail_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vmul_unit.f ====
+incdir+rtl
rtl/vmul_insn_pkg.sv
rtl/vmul_data_pkg.sv
rtl/vmul_insn_queue.sv
rtl/simd_mul.sv
rtl/vmul_result_queue.sv
rtl/vmul_unit.sv
tests/tb_clk_gen.sv
tests/vmul_unit_scoreboard.sv
tests/vmul_unit_chk.sv
tests/tb_vmul_unit.sv

// ==== Makefile ====
SIM      := verilator
TOP      := tb_vmul_unit
FILELIST := vmul_unit.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG := *** TEST PASSED ***

SOURCES  := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard rtl/*.svh)
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
